//--- project.f
mem_pkg.sv
fetch_pkg.sv
fetch_pc.sv
icache.sv
cacheline_adapter.sv
fetch_top.sv
fetch_props.sv
fetch_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= fetch_tb
LOG       ?= sim.log
OBJ_DIR   ?= obj_dir
FILELIST  ?= project.f

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) --binary --timing --assert -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "Everything OK" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- fetch_tb.sv
module fetch_tb
import mem_pkg::*, fetch_pkg::*;
();

    localparam int     PERIOD       = 8;
    localparam int     RESET_CYCLES = 10;
    localparam int     NUM_SETS     = 16;
    localparam instr_t WORD_PATTERN = 32'h5a3c_96e1;
    // cycle budgets of the six tests.
    localparam int     TOTAL_BUDGET = 300 + 200 + 600 + 300 + 600 + 800;

    logic       clk;
    logic       rst;
    logic       redirect;
    pc_t        redirect_pc;
    logic       instr_valid;
    instr_t     instr;
    pc_t        instr_pc;
    logic       instr_ready;
    mem_addr_t  bmem_addr;
    logic       bmem_read;
    logic       bmem_ready;
    mem_addr_t  bmem_raddr;
    beat_t      bmem_rdata;
    logic       bmem_rvalid;

    integer     seed = 61595;
    logic       stall_en;
    instr_t     got_instr[$];
    pc_t        got_pc[$];
    mem_addr_t  read_log[$];    // line addresses of accepted burst reads.

    fetch_top #(.NUM_SETS(NUM_SETS)) fetch_top_inst (.*);

    function automatic instr_t model_word(input mem_addr_t addr);
        model_word = instr_t'(addr >> 2) ^ WORD_PATTERN;
    endfunction

    task automatic check_instr(input string name, input instr_t exp, input instr_t act);
        if (exp !== act) begin
            $display("CHECK FAILED %s: instr expected %h actual %h", name, exp, act);
            $display("Something failed");
            $fatal(1);
        end
    endtask

    task automatic check_pc(input string name, input pc_t exp, input pc_t act);
        if (exp !== act) begin
            $display("CHECK FAILED %s: pc expected %h actual %h", name, exp, act);
            $display("Something failed");
            $fatal(1);
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    initial begin
        #((RESET_CYCLES + TOTAL_BUDGET) * PERIOD);
        $display("timeout: the tests did not finish in their cycle budget");
        $display("Something failed");
        $fatal(1);
    end

    // output monitor, sampled mid-cycle.
    always @(negedge clk) begin
        if (!rst && instr_valid && instr_ready) begin
            got_instr.push_back(instr);
            got_pc.push_back(instr_pc);
        end
    end

    always @(posedge clk) begin
        #1;
        instr_ready = stall_en ? 1'($random(seed)) : 1'b1;
    end

    // burst memory model.
    initial begin
        mem_addr_t line_addr;
        int        gap;
        forever begin
            @(negedge clk);
            if (bmem_read && bmem_ready) begin
                line_addr = bmem_addr;
                read_log.push_back(line_addr);
                @(posedge clk);
                #1;
                bmem_ready = 1'b0;
                for (int b = 0; b < BEATS_PER_LINE; b++) begin
                    gap = $unsigned($random(seed)) % 3;
                    bmem_rvalid = 1'b0;
                    repeat (gap) begin
                        @(posedge clk);
                        #1;
                    end
                    bmem_rvalid = 1'b1;
                    bmem_raddr  = line_addr;
                    bmem_rdata  = {model_word(line_addr + 8 * b + 4),
                                   model_word(line_addr + 8 * b)};
                    @(posedge clk);
                    #1;
                end
                bmem_rvalid = 1'b0;
            end else begin
                @(posedge clk);
                #1;
                bmem_ready = ($random(seed) & 3) != 0;   // low about a quarter of the time.
            end
        end
    end

    task automatic redirect_to(input pc_t pc);
        redirect    = 1'b1;
        redirect_pc = pc;
        @(posedge clk);
        #1;
        redirect = 1'b0;
        got_instr.delete();
        got_pc.delete();
    endtask

    // waits for n outputs and checks them as a run from start_pc.
    task automatic expect_run(input string name, input pc_t start_pc, input int n);
        pc_t exp_pc;
        while (got_pc.size() < n) begin
            @(posedge clk);
            #1;
        end
        for (int i = 0; i < n; i++) begin
            exp_pc = start_pc + pc_t'(4 * i);
            check_pc(name, exp_pc, got_pc[i]);
            check_instr(name, model_word(exp_pc), got_instr[i]);
        end
    endtask

    task automatic cold_start();
        expect_run("cold_start", PC_RESET, 8);
    endtask

    task automatic second_pass();
        read_log.delete();
        redirect_to(PC_RESET);
        expect_run("second_pass", PC_RESET, 8);
        foreach (read_log[i]) begin
            if (read_log[i] == mem_addr_t'(PC_RESET)) begin
                $display("second_pass: line %h was read from memory again instead of hitting",
                         PC_RESET);
                $display("Something failed");
                $fatal(1);
            end
        end
    endtask

    task automatic output_stall();
        stall_en = 1'b1;
        redirect_to(PC_RESET + 32'h100);
        expect_run("output_stall", PC_RESET + 32'h100, 20);
        stall_en = 1'b0;
    endtask

    task automatic redirect_line();
        redirect_to(PC_RESET + 32'h2c4);
        expect_run("redirect_line", PC_RESET + 32'h2c4, 6);
    endtask

    task automatic set_conflict();
        for (int r = 0; r < 3; r++) begin
            redirect_to(PC_RESET);
            expect_run("set_conflict", PC_RESET, 4);
            redirect_to(PC_RESET + pc_t'(NUM_SETS * LINE_BYTES));
            expect_run("set_conflict", PC_RESET + pc_t'(NUM_SETS * LINE_BYTES), 4);
        end
    endtask

    task automatic line_assembly();
        stall_en = 1'b1;
        redirect_to(PC_RESET + 32'h4000);
        expect_run("line_assembly", PC_RESET + 32'h4000, 24);
        stall_en = 1'b0;
    endtask

    initial begin
        stall_en    = 1'b0;
        rst         = 1'b1;
        redirect    = 1'b0;
        redirect_pc = '0;
        instr_ready = 1'b0;
        bmem_ready  = 1'b0;
        bmem_raddr  = '0;
        bmem_rdata  = '0;
        bmem_rvalid = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst = 1'b0;
        cold_start();
        second_pass();
        output_stall();
        redirect_line();
        set_conflict();
        line_assembly();
        $display("Everything OK");
        $finish;
    end

endmodule : fetch_tb

//--- fetch_props.sv
module fetch_props
import mem_pkg::*, fetch_pkg::*;
(
    input   logic       clk,
    input   logic       rst,
    input   logic       redirect,
    input   logic       instr_valid,
    input   instr_t     instr,
    input   pc_t        instr_pc,
    input   logic       instr_ready,
    input   mem_addr_t  bmem_addr,
    input   logic       bmem_read,
    input   logic       bmem_ready,
    input   logic       fill_done
);

    logic burst_busy;   // a read was accepted, line not yet delivered.

    always_ff @(posedge clk) begin
        if (rst) begin
            burst_busy <= 1'b0;
        end else if (bmem_read && bmem_ready) begin
            burst_busy <= 1'b1;
        end else if (fill_done) begin
            burst_busy <= 1'b0;
        end
    end

    read_held: assert property (@(posedge clk) disable iff (rst)
        bmem_read && !bmem_ready |=> bmem_read && $stable(bmem_addr))
        else $error("burst read dropped or address changed before ready");

    out_held: assert property (@(posedge clk) disable iff (rst)
        instr_valid && !instr_ready && !redirect |=>
            instr_valid && $stable(instr) && $stable(instr_pc))
        else $error("output changed while stalled");

    one_burst: assert property (@(posedge clk) disable iff (rst)
        burst_busy |-> !bmem_read)
        else $error("burst read issued while a fill is running");

endmodule : fetch_props

bind fetch_top fetch_props fetch_props_inst (.*);

//--- fetch_top.sv
module fetch_top
import mem_pkg::*, fetch_pkg::*;
#(
    parameter int NUM_SETS = 16
)
(
    input   logic       clk,
    input   logic       rst,

    input   logic       redirect,
    input   pc_t        redirect_pc,

    output  logic       instr_valid,
    output  instr_t     instr,
    output  pc_t        instr_pc,
    input   logic       instr_ready,

    output  mem_addr_t  bmem_addr,
    output  logic       bmem_read,
    input   logic       bmem_ready,

    input   mem_addr_t  bmem_raddr,
    input   beat_t      bmem_rdata,
    input   logic       bmem_rvalid
);

    logic       req_valid;
    logic       req_ready;
    pc_t        req_pc;

    logic       fill_req;
    mem_addr_t  fill_addr;
    line_t      fill_line;
    logic       fill_done;

    fetch_pc fetch_pc_inst (
        .clk         (clk),
        .rst         (rst),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .req_ready   (req_ready),
        .req_valid   (req_valid),
        .req_pc      (req_pc)
    );

    icache #(
        .NUM_SETS (NUM_SETS)
    ) icache_inst (
        .clk         (clk),
        .rst         (rst),
        .req_valid   (req_valid),
        .req_pc      (req_pc),
        .req_ready   (req_ready),
        .redirect    (redirect),
        .instr_valid (instr_valid),
        .instr       (instr),
        .instr_pc    (instr_pc),
        .instr_ready (instr_ready),
        .fill_req    (fill_req),
        .fill_addr   (fill_addr),
        .fill_line   (fill_line),
        .fill_done   (fill_done)
    );

    cacheline_adapter cacheline_adapter_inst (
        .clk         (clk),
        .rst         (rst),
        .fill_req    (fill_req),
        .fill_addr   (fill_addr),
        .fill_line   (fill_line),
        .fill_done   (fill_done),
        .bmem_addr   (bmem_addr),
        .bmem_read   (bmem_read),
        .bmem_ready  (bmem_ready),
        .bmem_raddr  (bmem_raddr),
        .bmem_rdata  (bmem_rdata),
        .bmem_rvalid (bmem_rvalid)
    );

endmodule : fetch_top

//--- cacheline_adapter.sv
module cacheline_adapter
import mem_pkg::*;
(
    input   logic       clk,
    input   logic       rst,

    input   logic       fill_req,
    input   mem_addr_t  fill_addr,
    output  line_t      fill_line,
    output  logic       fill_done,

    output  mem_addr_t  bmem_addr,
    output  logic       bmem_read,
    input   logic       bmem_ready,

    input   mem_addr_t  bmem_raddr,
    input   beat_t      bmem_rdata,
    input   logic       bmem_rvalid
);

    typedef enum logic [1:0] {
        AD_IDLE,
        AD_ISSUE,
        AD_COLLECT
    } ad_state_t;

    ad_state_t  state;
    beat_cnt_t  beat_cnt;
    line_t      line_q;
    logic       beat_hit;
    logic       last_beat;

    assign bmem_read = (state == AD_ISSUE);
    assign bmem_addr = line_align(fill_addr);
    assign fill_line = line_q;

    // only beats for our own line count.
    assign beat_hit  = (state == AD_COLLECT) && bmem_rvalid && (bmem_raddr == bmem_addr);
    assign last_beat = (beat_cnt == beat_cnt_t'(BEATS_PER_LINE - 1));

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= AD_IDLE;
            beat_cnt  <= '0;
            fill_done <= 1'b0;
        end else begin
            fill_done <= 1'b0;
            unique case (state)
                AD_IDLE: begin
                    // cache still holds fill_req during the done pulse.
                    if (fill_req && !fill_done) begin
                        state <= AD_ISSUE;
                    end
                end
                AD_ISSUE: begin
                    if (bmem_ready) begin
                        state    <= AD_COLLECT;
                        beat_cnt <= '0;
                    end
                end
                AD_COLLECT: begin
                    if (beat_hit) begin
                        beat_cnt <= beat_cnt + beat_cnt_t'(1);
                        if (last_beat) begin
                            state     <= AD_IDLE;
                            fill_done <= 1'b1;
                        end
                    end
                end
                default: state <= AD_IDLE;
            endcase
        end
    end

    // shift in from the top so beat 0 ends up lowest.
    always_ff @(posedge clk) begin
        if (beat_hit) begin
            line_q <= {bmem_rdata, line_q[$bits(line_t)-1:$bits(beat_t)]};
        end
    end

endmodule : cacheline_adapter

//--- icache.sv
module icache
import mem_pkg::*, fetch_pkg::*;
#(
    parameter int NUM_SETS = 16
)
(
    input   logic       clk,
    input   logic       rst,

    input   logic       req_valid,
    input   pc_t        req_pc,
    output  logic       req_ready,

    input   logic       redirect,

    output  logic       instr_valid,
    output  instr_t     instr,
    output  pc_t        instr_pc,
    input   logic       instr_ready,

    output  logic       fill_req,
    output  mem_addr_t  fill_addr,
    input   line_t      fill_line,
    input   logic       fill_done
);

    localparam int OFF_BITS  = $clog2(LINE_BYTES);
    localparam int IDX_BITS  = $clog2(NUM_SETS);
    localparam int TAG_BITS  = $bits(pc_t) - OFF_BITS - IDX_BITS;
    localparam int WSEL_LO   = $clog2(INSTR_BYTES);
    localparam int WSEL_BITS = OFF_BITS - WSEL_LO;
    localparam int WORD_BITS = $bits(instr_t);

    typedef enum logic {
        ST_IDLE,
        ST_FILL
    } ic_state_t;

    ic_state_t state;

    line_t                 line_arr [NUM_SETS];
    logic [TAG_BITS-1:0]   tag_arr  [NUM_SETS];
    logic [NUM_SETS-1:0]   valid_arr;

    logic [IDX_BITS-1:0]   req_idx;
    logic [TAG_BITS-1:0]   req_tag;
    logic [WSEL_BITS-1:0]  req_word;
    logic                  hit;
    logic                  accept;
    instr_t                hit_word;

    pc_t                   miss_pc;
    logic                  miss_drop;
    logic [IDX_BITS-1:0]   miss_idx;
    logic [TAG_BITS-1:0]   miss_tag;
    logic [WSEL_BITS-1:0]  miss_word;
    logic                  fill_resp;

    assign req_idx  = req_pc[OFF_BITS +: IDX_BITS];
    assign req_tag  = req_pc[OFF_BITS + IDX_BITS +: TAG_BITS];
    assign req_word = req_pc[WSEL_LO +: WSEL_BITS];

    assign miss_idx  = miss_pc[OFF_BITS +: IDX_BITS];
    assign miss_tag  = miss_pc[OFF_BITS + IDX_BITS +: TAG_BITS];
    assign miss_word = miss_pc[WSEL_LO +: WSEL_BITS];

    assign hit      = valid_arr[req_idx] && (tag_arr[req_idx] == req_tag);
    assign hit_word = line_arr[req_idx][req_word * WORD_BITS +: WORD_BITS];

    // new work only when idle and the output slot frees up.
    assign req_ready = (state == ST_IDLE) && (!instr_valid || instr_ready);
    assign accept    = req_valid && req_ready && !redirect;   // redirect kills the old request.

    // fill answers the core unless a redirect came in meanwhile.
    assign fill_resp = (state == ST_FILL) && fill_done && !miss_drop && !redirect;

    assign fill_req  = (state == ST_FILL);
    assign fill_addr = line_align(mem_addr_t'(miss_pc));

    always_ff @(posedge clk) begin
        if (rst) begin
            state       <= ST_IDLE;
            miss_drop   <= 1'b0;
            instr_valid <= 1'b0;
        end else begin
            unique case (state)
                ST_IDLE: begin
                    if (accept && !hit) begin
                        state     <= ST_FILL;
                        miss_drop <= 1'b0;
                    end
                end
                ST_FILL: begin
                    if (fill_done) begin
                        state <= ST_IDLE;
                    end else if (redirect) begin
                        miss_drop <= 1'b1;      // line still lands in the array.
                    end
                end
                default: state <= ST_IDLE;
            endcase

            if ((accept && hit) || fill_resp) begin
                instr_valid <= 1'b1;
            end else if (redirect || instr_ready) begin
                instr_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_arr <= '0;
        end else if ((state == ST_FILL) && fill_done) begin
            valid_arr[miss_idx] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if ((state == ST_FILL) && fill_done) begin
            line_arr[miss_idx] <= fill_line;
            tag_arr[miss_idx]  <= miss_tag;
        end
    end

    always_ff @(posedge clk) begin
        if (accept && !hit) begin
            miss_pc <= req_pc;
        end
        if (accept && hit) begin
            instr    <= hit_word;
            instr_pc <= req_pc;
        end else if (fill_resp) begin
            instr    <= fill_line[miss_word * WORD_BITS +: WORD_BITS];
            instr_pc <= miss_pc;
        end
    end

endmodule : icache

//--- fetch_pc.sv
module fetch_pc
import fetch_pkg::*;
(
    input   logic   clk,
    input   logic   rst,

    input   logic   redirect,
    input   pc_t    redirect_pc,

    input   logic   req_ready,
    output  logic   req_valid,
    output  pc_t    req_pc
);

    always_ff @(posedge clk) begin
        if (rst) begin
            req_valid <= 1'b0;
            req_pc    <= PC_RESET;
        end else begin
            req_valid <= 1'b1;                          // always asking once out of reset.
            if (redirect) begin
                req_pc <= redirect_pc;                  // redirect beats the step.
            end else if (req_valid && req_ready) begin
                req_pc <= req_pc + pc_t'(INSTR_BYTES);
            end
        end
    end

endmodule : fetch_pc

//--- fetch_pkg.sv
package fetch_pkg;

    typedef logic [31:0] pc_t;
    typedef logic [31:0] instr_t;

    // byte step between consecutive fetches.
    localparam int INSTR_BYTES = 4;

    localparam pc_t PC_RESET = 32'h1eceb000;

endpackage : fetch_pkg

//--- mem_pkg.sv
package mem_pkg;

    localparam int BEAT_BITS      = 64;
    localparam int BEATS_PER_LINE = 4;
    localparam int LINE_BYTES     = 32;

    typedef logic [31:0]                         mem_addr_t;
    typedef logic [BEAT_BITS-1:0]                beat_t;
    typedef logic [BEATS_PER_LINE*BEAT_BITS-1:0] line_t;    // beat 0 in the low bits.

    // counts beats within one burst.
    typedef logic [$clog2(BEATS_PER_LINE)-1:0] beat_cnt_t;

    // clears the byte offset within a line.
    function automatic mem_addr_t line_align(input mem_addr_t addr);
        line_align = addr & ~mem_addr_t'(LINE_BYTES - 1);
    endfunction

endpackage : mem_pkg
